// File: bp_params.svh
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// pcs count instruction words
`define BP_PC_W 32

// table index from the pc low byte
`define BP_IDX_W 8

// tag is whatever is left above the index
`define BP_TAG_W (`BP_PC_W - `BP_IDX_W)

// global history, in resolved jumps
`define BP_HIST_W 2

// saturating counter
`define BP_CNT_W 2

// weakly not taken
`define BP_CNT_INIT 1

`endif

// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int instr_w = 32;
  localparam int opc_w   = 7; // opcode field sits at [6:0]

  // opcode field values of the jump kinds
  localparam logic [opc_w-1:0] opc_jal    = 7'b1101111;
  localparam logic [opc_w-1:0] opc_jalr   = 7'b1100111;
  localparam logic [opc_w-1:0] opc_branch = 7'b1100011;

  // class of a fetched word, as far as prediction cares
  typedef enum logic [1:0] {
    op_jal,
    op_jalr,
    op_cond_branch,
    op_other
  } opcode_e;

endpackage

`default_nettype wire

// File: bp_pkg.sv
`default_nettype none
`include "bp_params.svh"

package bp_pkg;

  typedef logic [`BP_HIST_W-1:0] hist_t;
  typedef logic [`BP_CNT_W-1:0]  cnt_t;

  // one target cache line
  typedef struct packed {
    logic [`BP_TAG_W-1:0] tag;
    logic [`BP_PC_W-1:0]  target;
  } btac_entry_t;

  // fetch side result, travels with the instruction
  typedef struct packed {
    logic [`BP_PC_W-1:0] next_pc;
    hist_t               hist;    // history used for the lookup
    logic                is_jump;
  } pred_t;

  // outcome of an executed jump
  typedef struct packed {
    logic                valid;
    logic [`BP_PC_W-1:0] pc;
    hist_t               hist;
    logic                taken;
    logic [`BP_PC_W-1:0] actual_pc;
    logic [`BP_PC_W-1:0] pred_pc;
  } resolve_t;

  // write into counter table and target cache
  typedef struct packed {
    logic                 we;
    logic [`BP_IDX_W-1:0] idx;
    hist_t                hist;
    cnt_t                 cnt;
    logic                 tgt_we;
    logic [`BP_TAG_W-1:0] tag;
    logic [`BP_PC_W-1:0]  target;
  } tbl_upd_t;

endpackage

`default_nettype wire

// File: pattern_table.sv
`timescale 1ns/100ps
`default_nettype none
`include "bp_params.svh"

module pattern_table (
  input  wire                 clk,
  input  wire                 rstn,
  // fetch side lookup
  input  wire [`BP_IDX_W-1:0] rd_idx,
  input  bp_pkg::hist_t       rd_hist,
  output bp_pkg::cnt_t        rd_cnt,
  // resolve side lookup
  input  wire [`BP_IDX_W-1:0] chk_idx,
  input  bp_pkg::hist_t       chk_hist,
  output bp_pkg::cnt_t        chk_cnt,
  input  bp_pkg::tbl_upd_t    upd
);

  localparam int rows = 1 << `BP_IDX_W;
  localparam int cols = 1 << `BP_HIST_W;

  bp_pkg::cnt_t cnt_mem [rows][cols];

  // both reads are asynchronous
  assign rd_cnt  = cnt_mem[rd_idx][rd_hist];
  assign chk_cnt = cnt_mem[chk_idx][chk_hist];

  always_ff @(posedge clk) begin
    if (rstn) begin
      for (int i = 0; i < rows; i++) begin
        for (int j = 0; j < cols; j++) begin
          cnt_mem[i][j] <= bp_pkg::cnt_t'(`BP_CNT_INIT);
        end
      end
    end else if (upd.we) begin
      cnt_mem[upd.idx][upd.hist] <= upd.cnt;
    end
  end

endmodule

`default_nettype wire

// File: target_cache.sv
`timescale 1ns/100ps
`default_nettype none
`include "bp_params.svh"

module target_cache (
  input  wire                  clk,
  input  wire                  rstn,
  input  wire [`BP_IDX_W-1:0]  rd_idx,
  output bp_pkg::btac_entry_t  entry,
  input  bp_pkg::tbl_upd_t     upd
);

  localparam int depth = 1 << `BP_IDX_W;

  bp_pkg::btac_entry_t btac_mem [depth];
  bp_pkg::btac_entry_t wr_entry;

  // raw line out, the tag compare is done at fetch
  assign entry = btac_mem[rd_idx];

  assign wr_entry.tag    = upd.tag;
  assign wr_entry.target = upd.target;

  always_ff @(posedge clk) begin
    if (rstn) begin
      for (int i = 0; i < depth; i++) begin
        btac_mem[i] <= '0;
      end
    end else if (upd.tgt_we) begin
      btac_mem[upd.idx] <= wr_entry;
    end
  end

endmodule

`default_nettype wire

// File: fetch_predict.sv
`timescale 1ns/100ps
`default_nettype none
`include "bp_params.svh"

module fetch_predict (
  input  wire [`BP_PC_W-1:0]             fetch_pc,
  input  wire [rv_isa_pkg::instr_w-1:0]  fetch_instr,
  input  bp_pkg::hist_t                  history,
  input  bp_pkg::cnt_t                   cnt,
  input  bp_pkg::btac_entry_t            entry,
  output logic [`BP_IDX_W-1:0]           rd_idx,
  output bp_pkg::hist_t                  rd_hist,
  output bp_pkg::pred_t                  pred
);

  rv_isa_pkg::opcode_e op_class;
  logic                is_jump;
  logic                tag_hit;
  logic                use_target;

  always_comb begin
    case (fetch_instr[rv_isa_pkg::opc_w-1:0])
      rv_isa_pkg::opc_jal:    op_class = rv_isa_pkg::op_jal;
      rv_isa_pkg::opc_jalr:   op_class = rv_isa_pkg::op_jalr;
      rv_isa_pkg::opc_branch: op_class = rv_isa_pkg::op_cond_branch;
      default:                op_class = rv_isa_pkg::op_other;
    endcase
  end

  assign is_jump = (op_class != rv_isa_pkg::op_other);

  assign rd_idx  = fetch_pc[`BP_IDX_W-1:0];
  assign rd_hist = history;

  assign tag_hit    = (entry.tag == fetch_pc[`BP_PC_W-1:`BP_IDX_W]);
  assign use_target = is_jump && cnt[`BP_CNT_W-1] && tag_hit; // counter msb = taken

  assign pred.next_pc = use_target ? entry.target : fetch_pc + 1'b1;
  assign pred.hist    = history; // snapshot for resolve time
  assign pred.is_jump = is_jump;

endmodule

`default_nettype wire

// File: branch_resolve.sv
`timescale 1ns/100ps
`default_nettype none
`include "bp_params.svh"

module branch_resolve (
  input  wire                  clk,
  input  wire                  rstn,
  input  bp_pkg::resolve_t     res,
  output logic [`BP_IDX_W-1:0] chk_idx,
  output bp_pkg::hist_t        chk_hist,
  input  bp_pkg::cnt_t         chk_cnt,
  output bp_pkg::hist_t        history,
  output bp_pkg::tbl_upd_t     upd,
  output logic                 mispredict,
  output logic [`BP_PC_W-1:0]  redirect_pc,
  output logic                 stat_valid,
  output logic                 stat_miss
);

  localparam bp_pkg::cnt_t cnt_max = {`BP_CNT_W{1'b1}};
  localparam bp_pkg::cnt_t cnt_min = '0;

  logic         miss;
  bp_pkg::cnt_t cnt_next;

  // counter that was used for this prediction
  assign chk_idx  = res.pc[`BP_IDX_W-1:0];
  assign chk_hist = res.hist;

  assign miss = res.valid && (res.actual_pc != res.pred_pc);

  always_comb begin
    if (res.taken) begin
      cnt_next = (chk_cnt == cnt_max) ? cnt_max : chk_cnt + 1'b1;
    end else begin
      cnt_next = (chk_cnt == cnt_min) ? cnt_min : chk_cnt - 1'b1;
    end
  end

  assign upd.we     = res.valid;
  assign upd.idx    = chk_idx;
  assign upd.hist   = res.hist;
  assign upd.cnt    = cnt_next;
  assign upd.tgt_we = miss && res.taken; // learn target only on a wrong taken jump
  assign upd.tag    = res.pc[`BP_PC_W-1:`BP_IDX_W];
  assign upd.target = res.actual_pc;

  assign stat_valid = res.valid;
  assign stat_miss  = miss;

  always_ff @(posedge clk) begin
    if (rstn) begin
      history    <= '0;
      mispredict <= 1'b0;
    end else begin
      mispredict <= miss;
      if (res.valid) begin
        history <= {history[`BP_HIST_W-2:0], res.taken};
      end
    end
  end

  // held until the next miss
  always_ff @(posedge clk) begin
    if (miss) begin
      redirect_pc <= res.actual_pc;
    end
  end

endmodule

`default_nettype wire

// File: pred_stats.sv
`timescale 1ns/100ps
`default_nettype none

module pred_stats (
  input  wire         clk,
  input  wire         rstn,
  input  wire         stat_valid,
  input  wire         stat_miss,
  output logic [31:0] total,
  output logic [31:0] hits,
  output logic [31:0] misses
);

  logic hit;

  // a miss strobe only comes with a valid one
  assign hit = stat_valid && !stat_miss;

  always_ff @(posedge clk) begin
    if (rstn) begin
      total  <= '0;
      hits   <= '0;
      misses <= '0;
    end else begin
      if (stat_valid) begin
        total <= total + 1'b1;
      end
      if (hit) begin
        hits <= hits + 1'b1;
      end
      if (stat_miss) begin
        misses <= misses + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: branch_predictor.sv
`timescale 1ns/100ps
`default_nettype none
`include "bp_params.svh"

module branch_predictor (
  input  wire                            clk,
  input  wire                            rstn,
  input  wire [`BP_PC_W-1:0]             fetch_pc,
  input  wire [rv_isa_pkg::instr_w-1:0]  fetch_instr,
  output bp_pkg::pred_t                  pred,
  input  bp_pkg::resolve_t               res,
  output logic                           mispredict,
  output logic [`BP_PC_W-1:0]            redirect_pc,
  output logic [31:0]                    total,
  output logic [31:0]                    hits,
  output logic [31:0]                    misses
);

  logic [`BP_IDX_W-1:0] rd_idx;
  bp_pkg::hist_t        rd_hist;
  bp_pkg::cnt_t         rd_cnt;
  logic [`BP_IDX_W-1:0] chk_idx;
  bp_pkg::hist_t        chk_hist;
  bp_pkg::cnt_t         chk_cnt;
  bp_pkg::hist_t        history;
  bp_pkg::btac_entry_t  entry;
  bp_pkg::tbl_upd_t     upd;
  logic                 stat_valid;
  logic                 stat_miss;

  fetch_predict u_fetch_predict (
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr),
    .history     (history),
    .cnt         (rd_cnt),
    .entry       (entry),
    .rd_idx      (rd_idx),
    .rd_hist     (rd_hist),
    .pred        (pred)
  );

  pattern_table u_pattern_table (
    .clk      (clk),
    .rstn     (rstn),
    .rd_idx   (rd_idx),
    .rd_hist  (rd_hist),
    .rd_cnt   (rd_cnt),
    .chk_idx  (chk_idx),
    .chk_hist (chk_hist),
    .chk_cnt  (chk_cnt),
    .upd      (upd)
  );

  target_cache u_target_cache (
    .clk    (clk),
    .rstn   (rstn),
    .rd_idx (rd_idx),
    .entry  (entry),
    .upd    (upd)
  );

  branch_resolve u_branch_resolve (
    .clk         (clk),
    .rstn        (rstn),
    .res         (res),
    .chk_idx     (chk_idx),
    .chk_hist    (chk_hist),
    .chk_cnt     (chk_cnt),
    .history     (history),
    .upd         (upd),
    .mispredict  (mispredict),
    .redirect_pc (redirect_pc),
    .stat_valid  (stat_valid),
    .stat_miss   (stat_miss)
  );

  pred_stats u_pred_stats (
    .clk        (clk),
    .rstn       (rstn),
    .stat_valid (stat_valid),
    .stat_miss  (stat_miss),
    .total      (total),
    .hits       (hits),
    .misses     (misses)
  );

endmodule

`default_nettype wire

// File: tb_branch_predictor.sv
`timescale 1ns/100ps
`default_nettype none
`include "bp_params.svh"

module tb_branch_predictor;

  localparam int rand_cycles = 300;
  localparam int plan_cycles = 3 + 16 + rand_cycles + 4;
  localparam int cycle_limit = 2 * plan_cycles;

  localparam logic [31:0] pc_a       = 32'h0000_0310;
  localparam logic [31:0] tgt_a      = 32'h0000_0400;
  localparam logic [31:0] jal_word   = {25'h0, rv_isa_pkg::opc_jal};
  localparam logic [31:0] other_word = 32'h0000_0013; // addi

  // one prediction waiting for its outcome
  typedef struct packed {
    logic [`BP_PC_W-1:0] pc;
    bp_pkg::pred_t       pred;
  } flight_t;

  logic                clk;
  logic                rstn;
  logic [`BP_PC_W-1:0] fetch_pc;
  logic [31:0]         fetch_instr;
  bp_pkg::pred_t       pred;
  bp_pkg::resolve_t    res;
  logic                mispredict;
  logic [`BP_PC_W-1:0] redirect_pc;
  logic [31:0]         total;
  logic [31:0]         hits;
  logic [31:0]         misses;

  // reference model state
  bp_pkg::cnt_t         m_cnt [1 << `BP_IDX_W][1 << `BP_HIST_W];
  logic [`BP_TAG_W-1:0] m_tag [1 << `BP_IDX_W];
  logic [`BP_PC_W-1:0]  m_tgt [1 << `BP_IDX_W];
  bp_pkg::hist_t        m_hist;
  logic                 exp_miss;
  logic [`BP_PC_W-1:0]  exp_redirect;
  logic [31:0]          m_total;
  logic [31:0]          m_hits;
  logic [31:0]          m_misses;

  flight_t inflight [$];
  integer  seed = 32'hc19b;
  int      cycle_count = 0;
  int      n_resolved = 0;

  branch_predictor uut (
    .clk         (clk),
    .rstn        (rstn),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr),
    .pred        (pred),
    .res         (res),
    .mispredict  (mispredict),
    .redirect_pc (redirect_pc),
    .total       (total),
    .hits        (hits),
    .misses      (misses)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic reset_model();
    for (int i = 0; i < (1 << `BP_IDX_W); i++) begin
      for (int j = 0; j < (1 << `BP_HIST_W); j++) begin
        m_cnt[i][j] = bp_pkg::cnt_t'(`BP_CNT_INIT);
      end
      m_tag[i] = '0;
      m_tgt[i] = '0;
    end
    m_hist   = '0;
    exp_miss = 1'b0;
    m_total  = '0;
    m_hits   = '0;
    m_misses = '0;
  endtask

  // expected prediction from the model tables
  function automatic bp_pkg::pred_t ref_predict(input logic [31:0] pc, input logic [31:0] instr);
    bp_pkg::pred_t        p;
    logic [`BP_IDX_W-1:0] idx;
    logic                 hit;
    idx       = pc[`BP_IDX_W-1:0];
    p.is_jump = (instr[6:0] == rv_isa_pkg::opc_jal) || (instr[6:0] == rv_isa_pkg::opc_jalr)
                || (instr[6:0] == rv_isa_pkg::opc_branch);
    hit       = (m_tag[idx] == pc[`BP_PC_W-1:`BP_IDX_W]);
    p.hist    = m_hist;
    if (p.is_jump && m_cnt[idx][m_hist][`BP_CNT_W-1] && hit) begin
      p.next_pc = m_tgt[idx];
    end else begin
      p.next_pc = pc + 32'd1;
    end
    return p;
  endfunction

  task automatic model_resolve(input bp_pkg::resolve_t r);
    logic [`BP_IDX_W-1:0] idx;
    logic                 miss;
    bp_pkg::cnt_t         cnt;
    idx      = r.pc[`BP_IDX_W-1:0];
    miss     = r.valid && (r.actual_pc != r.pred_pc);
    exp_miss = miss;
    if (r.valid) begin
      cnt = m_cnt[idx][r.hist];
      if (r.taken && cnt != 2'd3) begin
        cnt = cnt + 2'd1;
      end else if (!r.taken && cnt != 2'd0) begin
        cnt = cnt - 2'd1;
      end
      m_cnt[idx][r.hist] = cnt;
      m_hist  = {m_hist[`BP_HIST_W-2:0], r.taken};
      m_total = m_total + 32'd1;
      if (miss) begin
        m_misses     = m_misses + 32'd1;
        exp_redirect = r.actual_pc;
      end else begin
        m_hits = m_hits + 32'd1;
      end
      if (miss && r.taken) begin
        m_tag[idx] = r.pc[`BP_PC_W-1:`BP_IDX_W];
        m_tgt[idx] = r.actual_pc;
      end
    end
  endtask

  // outcome of a jump at pc, resolved against the current model state
  function automatic bp_pkg::resolve_t fresh_res(input logic [31:0] pc, input logic taken,
                                                 input logic [31:0] actual);
    bp_pkg::resolve_t r;
    bp_pkg::pred_t    p;
    p           = ref_predict(pc, jal_word);
    r.valid     = 1'b1;
    r.pc        = pc;
    r.hist      = m_hist;
    r.taken     = taken;
    r.actual_pc = actual;
    r.pred_pc   = p.next_pc;
    return r;
  endfunction

  // small pool, low bytes collide on purpose
  function automatic logic [31:0] pool_pc(input logic [2:0] k);
    case (k)
      3'd0:    return 32'h0000_0010;
      3'd1:    return 32'h0000_0110;
      3'd2:    return 32'h0000_2010;
      3'd3:    return 32'h0000_0044;
      3'd4:    return 32'h0001_0044;
      3'd5:    return 32'h0000_00ff;
      3'd6:    return 32'h0000_0080;
      default: return 32'h0000_1080;
    endcase
  endfunction

  function automatic logic [31:0] rand_word(input logic [2:0] sel, input logic [31:0] upper);
    case (sel)
      3'd0, 3'd1: return {upper[31:7], rv_isa_pkg::opc_jal};
      3'd2:       return {upper[31:7], rv_isa_pkg::opc_jalr};
      3'd3, 3'd4: return {upper[31:7], rv_isa_pkg::opc_branch};
      default:    return {upper[31:7], 7'b0110011}; // alu op
    endcase
  endfunction

  task automatic apply(input logic [31:0] pc, input logic [31:0] instr,
                       input bp_pkg::resolve_t r);
    fetch_pc    <= pc;
    fetch_instr <= instr;
    res         <= r;
    if (r.valid) begin
      n_resolved++;
    end
  endtask

  initial begin : compare
    bp_pkg::pred_t exp_pred;
    forever begin
      @(negedge clk);
      if (!rstn) begin
        exp_pred = ref_predict(fetch_pc, fetch_instr);
        check("pred", pred, exp_pred);
        check("mispredict", mispredict, exp_miss);
        if (exp_miss) begin
          check("redirect_pc", redirect_pc, exp_redirect);
        end
        check("total", total, m_total);
        check("hits", hits, m_hits);
        check("misses", misses, m_misses);
        if (exp_pred.is_jump) begin
          inflight.push_back({fetch_pc, exp_pred});
        end
        model_resolve(res); // taken by the dut at the next edge
      end
    end
  end

  initial begin : stimulus
    bp_pkg::resolve_t r;
    flight_t          f;
    logic [31:0]      rnd;
    rstn        = 1'b1;
    fetch_pc    = '0;
    fetch_instr = '0;
    res         = '0;
    reset_model();
    repeat (3) @(posedge clk);
    rstn <= 1'b0;

    // cold tables
    @(posedge clk);
    apply(pc_a, jal_word, '0);
    @(negedge clk);
    check("pred.next_pc", pred.next_pc, pc_a + 32'd1);
    @(posedge clk);
    apply(pc_a, other_word, '0);
    @(negedge clk);
    check("pred.next_pc", pred.next_pc, pc_a + 32'd1);

    // first taken outcome is a miss
    @(posedge clk);
    apply(pc_a, jal_word, fresh_res(pc_a, 1'b1, tgt_a));
    @(posedge clk);
    apply(pc_a, jal_word, '0);
    @(negedge clk);
    check("mispredict", mispredict, 1'b1);
    check("redirect_pc", redirect_pc, tgt_a);
    @(posedge clk);
    apply(pc_a, jal_word, '0);
    @(negedge clk);
    check("mispredict", mispredict, 1'b0);

    // history ends at 11 with that counter at 2
    repeat (2) begin
      @(posedge clk);
      apply(pc_a, jal_word, fresh_res(pc_a, 1'b1, tgt_a));
    end
    @(posedge clk);
    apply(pc_a, jal_word, '0);
    @(negedge clk);
    check("pred.next_pc", pred.next_pc, tgt_a);

    // same low byte, other tag
    @(posedge clk);
    apply(pc_a + 32'h100, jal_word, '0);
    @(negedge clk);
    check("pred.next_pc", pred.next_pc, pc_a + 32'h101);

    @(posedge clk);
    inflight.delete();
    apply(pc_a, other_word, '0);

    // random fetches, outcomes resolved out of older snapshots
    repeat (rand_cycles) begin
      @(posedge clk);
      rnd = $random(seed);
      r   = '0;
      if (inflight.size() > 4 || (inflight.size() > 0 && rnd[9:8] != 2'd0)) begin
        f           = inflight.pop_front();
        r.valid     = 1'b1;
        r.pc        = f.pc;
        r.hist      = f.pred.hist;
        r.taken     = (rnd[11:10] != 2'd0);
        r.actual_pc = r.taken ? f.pc + (rnd[12] ? 32'h40 : 32'h80) : f.pc + 32'd1;
        r.pred_pc   = f.pred.next_pc;
      end
      apply(pool_pc(rnd[2:0]), rand_word(rnd[5:3], $random(seed)), r);
    end

    @(posedge clk);
    apply(pc_a, other_word, '0);
    @(posedge clk);
    @(negedge clk);
    check("total", total, n_resolved);
    check("hits + misses", hits + misses, n_resolved);

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
rv_isa_pkg.sv
bp_pkg.sv
pattern_table.sv
target_cache.sv
fetch_predict.sv
branch_resolve.sv
pred_stats.sv
branch_predictor.sv
tb_branch_predictor.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_branch_predictor -f sim.f
./obj_dir/Vtb_branch_predictor 2>&1 | tee sim.log

if grep -qx "TEST PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
